// ==== verilog/ahb_pkg.sv ====
package ahb_pkg;

    // transfer kind
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_t;

    // transfer size, only words are issued
    typedef enum logic [2:0] {
        SIZE_BYTE  = 3'b000,
        SIZE_HALF  = 3'b001,
        SIZE_WORD  = 3'b010,
        SIZE_DWORD = 3'b011
    } hsize_t;

    // master to slave signals
    // hwdata belongs to the data phase, the rest to the address phase
    typedef struct packed {
        logic [31:0] haddr;
        htrans_t     htrans;
        hsize_t      hsize;
        logic        hwrite;
        logic [31:0] hwdata;
    } ahb_m2s_t;

endpackage

// ==== verilog/xfer_pkg.sv ====
package xfer_pkg;

    // client request, addr is word aligned
    typedef struct packed {
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
    } xfer_req_t;

    // completion back to the client
    typedef struct packed {
        logic        write;
        logic        err;
        logic [31:0] rdata;
    } xfer_cpl_t;

endpackage

// ==== verilog/req_queue.sv ====
module req_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                hclk,
    input  logic                hrstn,
    input  logic                push,
    input  xfer_pkg::xfer_req_t push_req,
    input  logic                pop,
    output xfer_pkg::xfer_req_t head,
    output logic                not_empty
);
    import xfer_pkg::*;

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(QUEUE_DEPTH - 1);
    localparam logic [PTR_W:0] FULL_CNT = (PTR_W + 1)'(QUEUE_DEPTH);

    xfer_req_t        entries [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             full;

    // pointers wrap at the depth, which need not be a power of two
    always_ff @(posedge hclk) begin
        if (!hrstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge hclk) begin
        if (push) begin
            entries[wr_ptr] <= push_req;
        end
    end

    assign head      = entries[rd_ptr];
    assign not_empty = (count != '0);
    assign full      = (count == FULL_CNT);

    // client keeps no more requests outstanding than the depth
    push_when_full_a: assert property (
        @(posedge hclk) disable iff (!hrstn)
        push |-> !full
    ) else $error("req_queue: push while full");

    // master pops only a head it has put on the bus
    pop_when_empty_a: assert property (
        @(posedge hclk) disable iff (!hrstn)
        pop |-> not_empty
    ) else $error("req_queue: pop while empty");

endmodule

// ==== verilog/ahb_swc_master.sv ====
module ahb_swc_master (
    input  logic                hclk,
    input  logic                hrstn,
    input  xfer_pkg::xfer_req_t head,
    input  logic                not_empty,
    output logic                pop,
    output ahb_pkg::ahb_m2s_t   bus,
    input  logic                hready,
    input  logic                hresp,
    input  logic [31:0]         hrdata,
    output logic                cpl_valid,
    output xfer_pkg::xfer_cpl_t cpl
);
    import ahb_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_SETUP,
        S_WAIT
    } state_t;

    state_t      state;
    state_t      next_state;
    logic        load;
    logic [31:0] a_addr;
    logic        a_write;
    logic [31:0] a_wdata;
    logic        a_active;
    logic        a_wr_pend;
    logic        a_rd_pend;
    logic        d_wr_pend;
    logic        d_rd_pend;
    logic        d_done;
    logic [31:0] hwdata_q;

    always_ff @(posedge hclk) begin
        if (!hrstn) begin
            state <= S_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // an accepted address phase always drops back to idle, since the
    // queue head only moves on at the pop edge
    always_comb begin
        next_state = state;
        case (state)
            S_IDLE: begin
                if (hresp) begin
                    next_state = S_IDLE;
                end else if (not_empty) begin
                    next_state = S_SETUP;
                end else begin
                    next_state = S_IDLE;
                end
            end
            S_SETUP, S_WAIT: begin
                if (hresp) begin
                    // error in the data phase, drop the pipelined request
                    next_state = S_IDLE;
                end else if (!hready) begin
                    next_state = S_WAIT;
                end else begin
                    next_state = S_IDLE;
                end
            end
            default: next_state = S_IDLE;
        endcase
    end

    assign load      = (state == S_IDLE) && (next_state == S_SETUP);
    assign a_active  = (state != S_IDLE);
    assign a_wr_pend = a_active && a_write;
    assign a_rd_pend = a_active && !a_write;

    // address phase buffer
    always_ff @(posedge hclk) begin
        if (!hrstn) begin
            a_addr  <= '0;
            a_write <= 1'b0;
        end else if (load) begin
            a_addr  <= head.addr;
            a_write <= head.write;
        end
    end

    always_ff @(posedge hclk) begin
        if (load) begin
            a_wdata <= head.wdata;
        end
    end

    // direction moves into the data phase with hready
    always_ff @(posedge hclk) begin
        if (!hrstn) begin
            d_wr_pend <= 1'b0;
            d_rd_pend <= 1'b0;
        end else if (hready) begin
            d_wr_pend <= a_wr_pend;
            d_rd_pend <= a_rd_pend;
        end
    end

    always_ff @(posedge hclk) begin
        if (hready) begin
            hwdata_q <= a_wdata;
        end
    end

    always_comb begin
        bus.haddr  = a_addr;
        bus.htrans = a_active ? NONSEQ : IDLE;
        bus.hsize  = SIZE_WORD;
        bus.hwrite = a_write;
        bus.hwdata = hwdata_q;
    end

    assign pop    = a_active && hready && !hresp;
    assign d_done = hready && (d_wr_pend || d_rd_pend);

    always_ff @(posedge hclk) begin
        if (!hrstn) begin
            cpl_valid <= 1'b0;
        end else begin
            cpl_valid <= d_done;
        end
    end

    always_ff @(posedge hclk) begin
        if (d_done) begin
            cpl.write <= d_wr_pend;
            cpl.err   <= hresp;
            cpl.rdata <= d_rd_pend ? hrdata : '0;
        end
    end

    // held address phase may only be cut short by an error response
    addr_stable_a: assert property (
        @(posedge hclk) disable iff (!hrstn)
        (bus.htrans != IDLE) && !hready && !hresp |=>
            $stable(bus.haddr) && $stable(bus.htrans) && $stable(bus.hwrite)
    ) else $error("ahb_swc_master: address phase changed during wait");

    // only IDLE or NONSEQ, and nothing new in the second error cycle
    htrans_kind_a: assert property (
        @(posedge hclk) disable iff (!hrstn)
        (bus.htrans inside {IDLE, NONSEQ}) &&
            !(hresp && hready && (bus.htrans != IDLE))
    ) else $error("ahb_swc_master: htrans not allowed in this cycle");

    // issue bubble after each pop allows at most two completions in a row
    cpl_strobe_a: assert property (
        @(posedge hclk) disable iff (!hrstn)
        cpl_valid ##1 cpl_valid |=> !cpl_valid
    ) else $error("ahb_swc_master: cpl_valid held for three cycles");

endmodule

// ==== verilog/ahb_sram_slave.sv ====
module ahb_sram_slave #(
    parameter int MEM_WORDS = 256
) (
    input  logic              hclk,
    input  logic              hrstn,
    input  ahb_pkg::ahb_m2s_t bus,
    output logic              hready,
    output logic              hresp,
    output logic [31:0]       hrdata
);
    import ahb_pkg::*;

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam logic [31:0] MEM_BYTES = 32'(MEM_WORDS * 4);

    logic [31:0]      mem [MEM_WORDS];
    logic             in_range;
    logic             d_active;
    logic             d_write;
    logic [IDX_W-1:0] d_idx;
    logic [1:0]       wait_cnt;
    logic             err_first;
    logic             err_second;

    assign in_range = (bus.haddr < MEM_BYTES);

    // address phase is sampled whenever the bus is ready
    always_ff @(posedge hclk) begin
        if (!hrstn) begin
            d_active   <= 1'b0;
            d_write    <= 1'b0;
            d_idx      <= '0;
            wait_cnt   <= '0;
            err_first  <= 1'b0;
            err_second <= 1'b0;
        end else if (hready) begin
            err_second <= 1'b0;
            if (bus.htrans == NONSEQ) begin
                d_active  <= in_range;
                d_write   <= bus.hwrite;
                d_idx     <= bus.haddr[IDX_W+1:2];
                // bits 3:2 pick the number of wait states
                wait_cnt  <= in_range ? bus.haddr[3:2] : 2'd0;
                err_first <= !in_range;
            end else begin
                d_active  <= 1'b0;
                err_first <= 1'b0;
            end
        end else if (err_first) begin
            err_first  <= 1'b0;
            err_second <= 1'b1;
        end else begin
            wait_cnt <= wait_cnt - 2'd1;
        end
    end

    assign hready = !(err_first || (d_active && (wait_cnt != 2'd0)));
    assign hresp  = err_first || err_second;

    // write lands on the last data phase cycle
    always_ff @(posedge hclk) begin
        if (!hrstn) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (hready && d_active && d_write) begin
            mem[d_idx] <= bus.hwdata;
        end
    end

    // read straight from the array, so a write ending on the same edge
    // as the next address phase is already visible
    assign hrdata = (d_active && !d_write) ? mem[d_idx] : '0;

    err_two_cycle_a: assert property (
        @(posedge hclk) disable iff (!hrstn)
        hresp && !hready |=> hresp && hready
    ) else $error("ahb_sram_slave: error response not two cycles");

endmodule

// ==== verilog/ahb_xfer_top.sv ====
module ahb_xfer_top #(
    parameter int QUEUE_DEPTH = 4,
    parameter int MEM_WORDS   = 256
) (
    input  logic                hclk,
    input  logic                hrstn,
    input  logic                req_valid,
    input  xfer_pkg::xfer_req_t req,
    output logic                cpl_valid,
    output xfer_pkg::xfer_cpl_t cpl
);
    import ahb_pkg::*;
    import xfer_pkg::*;

    xfer_req_t   head;
    logic        not_empty;
    logic        pop;
    ahb_m2s_t    bus;
    logic        hready;
    logic        hresp;
    logic [31:0] hrdata;

    req_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_req_queue (
        .hclk      (hclk),
        .hrstn     (hrstn),
        .push      (req_valid),
        .push_req  (req),
        .pop       (pop),
        .head      (head),
        .not_empty (not_empty)
    );

    ahb_swc_master u_master (
        .hclk      (hclk),
        .hrstn     (hrstn),
        .head      (head),
        .not_empty (not_empty),
        .pop       (pop),
        .bus       (bus),
        .hready    (hready),
        .hresp     (hresp),
        .hrdata    (hrdata),
        .cpl_valid (cpl_valid),
        .cpl       (cpl)
    );

    ahb_sram_slave #(
        .MEM_WORDS (MEM_WORDS)
    ) u_sram (
        .hclk   (hclk),
        .hrstn  (hrstn),
        .bus    (bus),
        .hready (hready),
        .hresp  (hresp),
        .hrdata (hrdata)
    );

endmodule

// ==== tb/tb_ahb_xfer.sv ====
module tb_ahb_xfer;
    timeunit 1ns;
    timeprecision 100ps;

    import xfer_pkg::*;

    localparam int QUEUE_DEPTH = 4;
    localparam int MEM_WORDS   = 256;
    localparam int IDX_W       = $clog2(MEM_WORDS);
    localparam logic [31:0] MEM_BYTES = 32'(MEM_WORDS * 4);
    // test 2 pairs, test 3 mix, test 4 groups of four, test 5 rounds
    localparam int NUM_REQS    = 32 + 200 + 32 + 10 * QUEUE_DEPTH;
    localparam int CYCLE_LIMIT = 8 * NUM_REQS + 200;

    logic        hclk = 1'b0;
    logic        hrstn;
    logic        req_valid;
    xfer_req_t   req;
    logic        cpl_valid;
    xfer_cpl_t   cpl;

    logic [15:0] lfsr_state = 16'd29;
    logic [31:0] ref_mem [MEM_WORDS];
    xfer_cpl_t   exp_q [$];
    xfer_cpl_t   exp_cpl;
    int          issued;
    int          done_count;
    int          err_count;
    int          cycle_count;
    int          errs_before;

    ahb_xfer_top dut (
        .hclk      (hclk),
        .hrstn     (hrstn),
        .req_valid (req_valid),
        .req       (req),
        .cpl_valid (cpl_valid),
        .cpl       (cpl)
    );

    always #10 hclk = ~hclk;

    // taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // model is updated in request order, at issue time
    task automatic send_req(input logic wr, input logic [31:0] addr, input logic [31:0] data);
        xfer_cpl_t exp;
        logic      in_range;
        while (issued - done_count >= QUEUE_DEPTH) begin
            @(posedge hclk);
            #2;
        end
        in_range  = (addr < MEM_BYTES);
        exp.write = wr;
        exp.err   = !in_range;
        exp.rdata = '0;
        if (in_range && wr) begin
            ref_mem[addr[IDX_W+1:2]] = data;
        end else if (in_range) begin
            exp.rdata = ref_mem[addr[IDX_W+1:2]];
        end
        exp_q.push_back(exp);
        issued++;
        req_valid = 1'b1;
        req.write = wr;
        req.addr  = addr;
        req.wdata = data;
        @(posedge hclk);
        #2;
        req_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (done_count < issued) begin
            @(posedge hclk);
            #2;
        end
        repeat (2) begin
            @(posedge hclk);
            #2;
        end
    endtask

    task automatic report_test(input string name);
        $display("test %s: done, %0d errors", name, err_count - errs_before);
        errs_before = err_count;
    endtask

    always @(negedge hclk) begin
        if (hrstn && cpl_valid) begin
            if (exp_q.size() == 0) begin
                $display("completion strobe at %0t with no request outstanding", $time);
                err_count++;
            end else begin
                exp_cpl = exp_q.pop_front();
                done_count++;
                assert (cpl.write == exp_cpl.write) else begin
                    $display("[ERROR] %0t: write field %0b, expected %0b",
                             $time, cpl.write, exp_cpl.write);
                    err_count++;
                end
                assert (cpl.err == exp_cpl.err) else begin
                    $display("[ERROR] %0t: err %0b, expected %0b", $time, cpl.err, exp_cpl.err);
                    err_count++;
                end
                if (!exp_cpl.write && !exp_cpl.err) begin
                    assert (cpl.rdata == exp_cpl.rdata) else begin
                        $display("[ERROR] %0t: rdata %h, expected %h",
                                 $time, cpl.rdata, exp_cpl.rdata);
                        err_count++;
                    end
                end
            end
        end
    end

    always @(posedge hclk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            err_count++;
            $display("requests %0d, completions %0d, errors %0d", issued, done_count, err_count);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        logic [IDX_W-1:0] idx;
        logic [IDX_W-1:0] idx_list [QUEUE_DEPTH];
        int               half;
        hrstn     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = '0;
        end
        half = QUEUE_DEPTH / 2;

        // test 1: quiet during and after reset
        repeat (4) begin
            @(posedge hclk);
            #2;
            assert (cpl_valid == 1'b0) else begin
                $display("[ERROR] %0t: cpl_valid high during reset", $time);
                err_count++;
            end
        end
        hrstn = 1'b1;
        repeat (10) begin
            @(posedge hclk);
            #2;
            assert (cpl_valid == 1'b0) else begin
                $display("[ERROR] %0t: cpl_valid high with no requests", $time);
                err_count++;
            end
        end
        report_test("reset_idle");

        // test 2: write then read back
        for (int i = 0; i < 16; i++) begin
            idx = IDX_W'(rand_bits(IDX_W));
            send_req(1'b1, {idx, 2'b00}, rand_bits(32));
            send_req(1'b0, {idx, 2'b00}, '0);
        end
        wait_drain();
        report_test("write_read");

        // test 3: random mix with gaps
        for (int i = 0; i < 200; i++) begin
            idx = IDX_W'(rand_bits(IDX_W));
            send_req(1'(rand_bits(1)), {idx, 2'b00}, rand_bits(32));
            repeat (rand_bits(2)) begin
                @(posedge hclk);
                #2;
            end
        end
        wait_drain();
        report_test("random_mix");

        // test 4: error region aliases an in-range word
        for (int i = 0; i < 8; i++) begin
            idx = IDX_W'(rand_bits(IDX_W));
            send_req(1'b1, MEM_BYTES + {idx, 2'b00}, rand_bits(32));
            send_req(1'b0, {idx, 2'b00}, '0);
            send_req(1'b0, MEM_BYTES + (rand_bits(12) << 2), '0);
            send_req(1'b1, {IDX_W'(rand_bits(IDX_W)), 2'b00}, rand_bits(32));
        end
        wait_drain();
        report_test("error_region");

        // test 5: full queue back to back
        for (int r = 0; r < 10; r++) begin
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                idx_list[i] = IDX_W'(rand_bits(IDX_W));
            end
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                if (i < half) begin
                    send_req(1'b1, {idx_list[i], 2'b00}, rand_bits(32));
                end else begin
                    send_req(1'b0, {idx_list[i - half], 2'b00}, '0);
                end
            end
            wait_drain();
        end
        report_test("back_to_back");

        if (exp_q.size() != 0 || issued != done_count) begin
            $display("%0d requests were issued but only %0d completed", issued, done_count);
            err_count++;
        end
        $display("requests %0d, completions %0d, errors %0d", issued, done_count, err_count);
        if (err_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
verilog/ahb_pkg.sv
verilog/xfer_pkg.sv
verilog/req_queue.sv
verilog/ahb_swc_master.sv
verilog/ahb_sram_slave.sv
verilog/ahb_xfer_top.sv
tb/tb_ahb_xfer.sv
